// File: src/fetch_pkg.sv
package fetch_pkg;

	// datapath widths
	localparam int XLEN = 64;
	localparam int ILEN = 32;

	// fetch starts at the ITCM base
	localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

	// memory and queue depths, as address widths
	localparam int ITCM_AW = 14;
	localparam int BHT_AW = 4;
	localparam int RAS_AW = 4;

	// major opcodes of the control transfer instructions
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// link registers ra and t0
	localparam logic [4:0] REG_RA = 5'd1;
	localparam logic [4:0] REG_T0 = 5'd5;

	// one instruction word seen through the J, I and B layouts
	typedef union packed {
		struct packed {
			logic imm20;
			logic [9:0] imm10_1;
			logic imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
		struct packed {
			logic [11:0] imm11_0;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i_fmt;
		struct packed {
			logic imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic imm11;
			logic [6:0] opcode;
		} b_fmt;
	} rv_instr_t;

endpackage

// File: src/itcm.sv
`timescale 1ns/1ps

module itcm
	import fetch_pkg::*;
(
	input  logic CLK,

	// fetch read port
	input  logic [ITCM_AW-1:0] raddr,
	output logic [ILEN-1:0] rdata,

	// preload port, used while the core sits in reset
	input  logic we,
	input  logic [ITCM_AW-1:0] waddr,
	input  logic [ILEN-1:0] wdata
);

	localparam int DEPTH = 1 << ITCM_AW;

	logic [ILEN-1:0] mem [0:DEPTH-1];

	// write side
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read, data appears one cycle after the address
	always_ff @(posedge CLK) begin
		rdata <= mem[raddr];
	end

endmodule

// File: src/branch_fifo.sv
`timescale 1ns/1ps

module branch_fifo
	import fetch_pkg::*;
(
	input  logic CLK,
	input  logic rst_n,

	input  logic push,
	input  logic pop,
	input  logic [XLEN:0] push_data,

	output logic full,
	output logic head_taken,
	output logic [XLEN-1:0] head_pc
);

	localparam int DEPTH = 1 << BHT_AW;

	logic [XLEN:0] mem [0:DEPTH-1];
	logic [XLEN:0] head_q;
	logic [BHT_AW-1:0] rd_ptr;
	logic [BHT_AW-1:0] wr_ptr;
	logic [BHT_AW:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == (BHT_AW+1)'(DEPTH));
	assign do_push = push & ~full;
	assign do_pop = pop & (count != '0);

	// pointers and occupancy
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (BHT_AW+1)'(do_push) - (BHT_AW+1)'(do_pop);
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// head register; the last popped entry stays visible when the queue drains
	always_ff @(posedge CLK) begin
		if (do_pop && count > (BHT_AW+1)'(1)) begin
			head_q <= mem[rd_ptr + 1'b1];
		end else if (do_push && (count == '0 || (do_pop && count == (BHT_AW+1)'(1)))) begin
			head_q <= push_data;
		end
	end

	assign head_taken = head_q[XLEN];
	assign head_pc = head_q[XLEN-1:0];

endmodule

// File: src/return_stack.sv
`timescale 1ns/1ps

module return_stack
	import fetch_pkg::*;
(
	input  logic CLK,
	input  logic rst_n,

	input  logic push,
	input  logic pop,
	input  logic [XLEN-1:0] push_data,

	output logic empty,
	output logic [XLEN-1:0] top
);

	localparam int DEPTH = 1 << RAS_AW;

	logic [XLEN-1:0] mem [0:DEPTH-1];
	logic [RAS_AW-1:0] sp;
	logic [RAS_AW:0] count;
	logic do_pop;

	assign empty = (count == '0);
	assign do_pop = pop & ~empty;

	// sp points at the newest entry; wrapping drops the oldest one
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			sp <= '1;
			count <= '0;
		end else if (push && do_pop) begin
			// call and return in one instruction, top is replaced
			count <= count;
		end else if (push) begin
			sp <= sp + 1'b1;
			if (count != (RAS_AW+1)'(DEPTH)) begin
				count <= count + 1'b1;
			end
		end else if (do_pop) begin
			sp <= sp - 1'b1;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push && do_pop) begin
			mem[sp] <= push_data;
		end else if (push) begin
			mem[sp + 1'b1] <= push_data;
		end
	end

	assign top = mem[sp];

endmodule

// File: src/instr_predecode.sv
`timescale 1ns/1ps

module instr_predecode
	import fetch_pkg::*;
(
	input  logic [ILEN-1:0] instr,

	output logic is_jal,
	output logic is_jalr,
	output logic is_branch,
	output logic is_call,
	output logic is_return,
	output logic [XLEN-1:0] imm
);

	rv_instr_t word;
	logic rd_link;
	logic rs1_link;

	assign word = instr;

	// opcode sits at the same place in every layout
	assign is_jal = (word.j_fmt.opcode == OPC_JAL);
	assign is_jalr = (word.i_fmt.opcode == OPC_JALR);
	assign is_branch = (word.b_fmt.opcode == OPC_BRANCH);

	assign rd_link = (word.i_fmt.rd == REG_RA) | (word.i_fmt.rd == REG_T0);
	assign rs1_link = (word.i_fmt.rs1 == REG_RA) | (word.i_fmt.rs1 == REG_T0);

	// link register hints, as in the ISA table for ra and t0
	assign is_call = (is_jal | is_jalr) & rd_link;
	assign is_return = is_jalr & rs1_link & (word.i_fmt.rs1 != word.i_fmt.rd);

	// sign-extended immediate of the matching layout
	always_comb begin
		if (is_jal) begin
			imm = {
				{(XLEN-21){word.j_fmt.imm20}},
				word.j_fmt.imm20,
				word.j_fmt.imm19_12,
				word.j_fmt.imm11,
				word.j_fmt.imm10_1,
				1'b0
			};
		end else if (is_jalr) begin
			imm = {
				{(XLEN-12){word.i_fmt.imm11_0[11]}},
				word.i_fmt.imm11_0
			};
		end else if (is_branch) begin
			imm = {
				{(XLEN-13){word.b_fmt.imm12}},
				word.b_fmt.imm12,
				word.b_fmt.imm11,
				word.b_fmt.imm10_5,
				word.b_fmt.imm4_1,
				1'b0
			};
		end else begin
			// not a control transfer, offset unused
			imm = '0;
		end
	end

endmodule

// File: src/pc_generate.sv
`timescale 1ns/1ps

module pc_generate
	import fetch_pkg::*;
(
	input  logic CLK,
	input  logic rst_n,

	// fetched word and its predecode
	input  logic [ILEN-1:0] rdata,
	input  logic is_jal,
	input  logic is_jalr,
	input  logic is_branch,
	input  logic is_call,
	input  logic is_return,
	input  logic [XLEN-1:0] imm,

	// execute and branch unit
	input  logic jalr_valid,
	input  logic [XLEN-1:0] jalr_pc,
	input  logic bru_res_valid,
	input  logic bru_taken,
	output logic bru_ready,
	output logic mispredict,

	// instruction queue
	input  logic fifo_full,
	output logic [ILEN-1:0] instr_out,
	output logic [XLEN-1:0] pc_out,
	output logic instr_valid,

	// ITCM read address
	output logic [XLEN-1:0] pc_next,

	// branch history FIFO
	input  logic bht_full,
	input  logic bht_head_taken,
	input  logic [XLEN-1:0] bht_head_pc,
	output logic bht_push,
	output logic bht_pop,
	output logic [XLEN:0] bht_push_data,

	// return address stack
	input  logic ras_empty,
	input  logic [XLEN-1:0] ras_top,
	output logic ras_push,
	output logic ras_pop,
	output logic [XLEN-1:0] ras_push_data
);

	logic [XLEN-1:0] pc_q;
	logic fetch_en;
	logic [XLEN-1:0] seq_pc;
	logic [XLEN-1:0] take_pc;
	logic [XLEN-1:0] alt_pc;
	logic predict_taken;
	logic ras_hit;
	logic jalr_stall;
	logic bht_stall;
	logic advance;

	assign seq_pc = pc_q + XLEN'(4);
	assign ras_hit = is_return & ~ras_empty;

	// jalr takes the stack top if it can, else waits for execute
	always_comb begin
		if (is_jalr) begin
			take_pc = ras_hit ? ras_top : jalr_pc;
		end else begin
			take_pc = pc_q + imm;
		end
	end

	// static rule, backward branches and all jumps taken
	assign predict_taken = is_jal | is_jalr | (is_branch & imm[XLEN-1]);
	assign alt_pc = predict_taken ? seq_pc : take_pc;

	assign jalr_stall = is_jalr & ~ras_hit & ~jalr_valid;
	assign bht_stall = is_branch & bht_full;
	assign advance = fetch_en & ~(fifo_full | jalr_stall | bht_stall);

	assign mispredict = bru_res_valid & (bru_taken ^ bht_head_taken);

	always_comb begin
		if (!advance) begin
			pc_next = pc_q;
		end else if (mispredict) begin
			pc_next = bht_head_pc;
		end else if (predict_taken) begin
			pc_next = take_pc;
		end else begin
			pc_next = seq_pc;
		end
	end

	// fetch_en stays low during reset so the ITCM keeps reading RESET_PC
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_PC;
			fetch_en <= 1'b0;
		end else begin
			pc_q <= pc_next;
			fetch_en <= 1'b1;
		end
	end

	assign pc_out = pc_q;
	assign instr_out = rdata;
	assign instr_valid = advance;
	assign bru_ready = ~jalr_stall & ~fifo_full;

	// prediction plus the path not taken, for the resolver
	assign bht_push = advance & is_branch;
	assign bht_pop = bru_res_valid;
	assign bht_push_data = {predict_taken, alt_pc};

	assign ras_push = advance & is_call;
	assign ras_pop = advance & ras_hit;
	assign ras_push_data = seq_pc;

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
	import fetch_pkg::*;
(
	input  logic CLK,
	input  logic rst_n,

	input  logic jalr_valid,
	input  logic [XLEN-1:0] jalr_pc,

	input  logic bru_res_valid,
	input  logic bru_taken,
	output logic bru_ready,

	input  logic fifo_full,

	input  logic imem_we,
	input  logic [ITCM_AW-1:0] imem_waddr,
	input  logic [ILEN-1:0] imem_wdata,

	output logic [ILEN-1:0] instr_out,
	output logic [XLEN-1:0] pc_out,
	output logic instr_valid,
	output logic mispredict
);

	logic [XLEN-1:0] pc_next;
	logic [ILEN-1:0] rdata;
	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_call;
	logic is_return;
	logic [XLEN-1:0] imm;
	logic bht_push;
	logic bht_pop;
	logic [XLEN:0] bht_push_data;
	logic bht_full;
	logic bht_head_taken;
	logic [XLEN-1:0] bht_head_pc;
	logic ras_push;
	logic ras_pop;
	logic [XLEN-1:0] ras_push_data;
	logic ras_empty;
	logic [XLEN-1:0] ras_top;

	pc_generate u_pc_generate (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.rdata         (rdata),
		.is_jal        (is_jal),
		.is_jalr       (is_jalr),
		.is_branch     (is_branch),
		.is_call       (is_call),
		.is_return     (is_return),
		.imm           (imm),
		.jalr_valid    (jalr_valid),
		.jalr_pc       (jalr_pc),
		.bru_res_valid (bru_res_valid),
		.bru_taken     (bru_taken),
		.bru_ready     (bru_ready),
		.mispredict    (mispredict),
		.fifo_full     (fifo_full),
		.instr_out     (instr_out),
		.pc_out        (pc_out),
		.instr_valid   (instr_valid),
		.pc_next       (pc_next),
		.bht_full      (bht_full),
		.bht_head_taken(bht_head_taken),
		.bht_head_pc   (bht_head_pc),
		.bht_push      (bht_push),
		.bht_pop       (bht_pop),
		.bht_push_data (bht_push_data),
		.ras_empty     (ras_empty),
		.ras_top       (ras_top),
		.ras_push      (ras_push),
		.ras_pop       (ras_pop),
		.ras_push_data (ras_push_data)
	);

	instr_predecode u_instr_predecode (
		.instr    (rdata),
		.is_jal   (is_jal),
		.is_jalr  (is_jalr),
		.is_branch(is_branch),
		.is_call  (is_call),
		.is_return(is_return),
		.imm      (imm)
	);

	// word address, the byte offset bits are dropped
	itcm u_itcm (
		.CLK  (CLK),
		.raddr(pc_next[ITCM_AW+1:2]),
		.rdata(rdata),
		.we   (imem_we),
		.waddr(imem_waddr),
		.wdata(imem_wdata)
	);

	branch_fifo u_branch_fifo (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.push      (bht_push),
		.pop       (bht_pop),
		.push_data (bht_push_data),
		.full      (bht_full),
		.head_taken(bht_head_taken),
		.head_pc   (bht_head_pc)
	);

	return_stack u_return_stack (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.push     (ras_push),
		.pop      (ras_pop),
		.push_data(ras_push_data),
		.empty    (ras_empty),
		.top      (ras_top)
	);

endmodule

// File: testbench/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts
	import fetch_pkg::*;
(
	input logic CLK,
	input logic rst_n,
	input logic bru_res_valid,
	input logic bru_ready,
	input logic fifo_full,
	input logic mispredict,
	input logic instr_valid,
	input logic [XLEN-1:0] pc_out,
	input logic [ILEN-1:0] instr_out
);

	// number of failed checks
	int fail_count = 0;

	// a redirect only comes with a resolution
	property mispredict_needs_res;
		@(posedge CLK) disable iff (!rst_n)
		mispredict |-> bru_res_valid;
	endproperty

	property full_blocks_valid;
		@(posedge CLK) disable iff (!rst_n)
		fifo_full |-> !instr_valid;
	endproperty

	// back-pressure freezes the fetch PC
	property full_holds_pc;
		@(posedge CLK) disable iff (!rst_n)
		fifo_full |=> $stable(pc_out);
	endproperty

	property pc_aligned;
		@(posedge CLK) disable iff (!rst_n)
		pc_out[1:0] == 2'b00;
	endproperty

	property outputs_known;
		@(posedge CLK) disable iff (!rst_n)
		!$isunknown({instr_out, pc_out, instr_valid, mispredict, bru_ready});
	endproperty

	a_mispredict: assert property (mispredict_needs_res)
		else begin
			fail_count++;
			$error("mispredict without bru_res_valid");
		end
	a_full_valid: assert property (full_blocks_valid)
		else begin
			fail_count++;
			$error("instr_valid high while fifo_full");
		end
	a_full_pc: assert property (full_holds_pc)
		else begin
			fail_count++;
			$error("pc_out moved after fifo_full");
		end
	a_aligned: assert property (pc_aligned)
		else begin
			fail_count++;
			$error("pc_out not word aligned");
		end
	a_known: assert property (outputs_known)
		else begin
			fail_count++;
			$error("unknown value on a fetch output");
		end

endmodule

bind fetch_top fetch_asserts u_fetch_asserts (.*);

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
	import fetch_pkg::*;
();

	localparam int PROG_LEN = 15;
	localparam int N_INSTR = 400;

	logic CLK;
	logic rst_n;
	logic jalr_valid;
	logic [XLEN-1:0] jalr_pc;
	logic bru_res_valid;
	logic bru_taken;
	logic bru_ready;
	logic fifo_full;
	logic imem_we;
	logic [ITCM_AW-1:0] imem_waddr;
	logic [ILEN-1:0] imem_wdata;
	logic [ILEN-1:0] instr_out;
	logic [XLEN-1:0] pc_out;
	logic instr_valid;
	logic mispredict;

	logic [ILEN-1:0] prog [0:PROG_LEN-1];
	logic prog_jal [0:PROG_LEN-1];
	logic prog_jalr [0:PROG_LEN-1];
	logic prog_br [0:PROG_LEN-1];
	logic prog_call [0:PROG_LEN-1];
	logic prog_ret [0:PROG_LEN-1];
	int prog_off [0:PROG_LEN-1];
	logic [XLEN:0] pred_q [$];
	logic [XLEN-1:0] stack_q [$];
	logic [31:0] seed;
	logic [XLEN-1:0] exp_pc;
	string test_name;
	int mismatches;
	int other_errors;
	int assert_fails;
	int accepted;
	int jalr_wait;
	int res_delay;

	fetch_top u_fetch_top (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// no test may need more than 40 cycles per accepted instruction
	initial begin
		repeat (N_INSTR * 40) @(posedge CLK);
		$display("timeout: fetch stopped accepting instructions");
		$display("Regression failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [ILEN-1:0] make_jal(logic [4:0] rd, int off);
		rv_instr_t w;
		logic [20:0] o;
		o = 21'(off);
		w.j_fmt.opcode = OPC_JAL;
		w.j_fmt.rd = rd;
		w.j_fmt.imm20 = o[20];
		w.j_fmt.imm19_12 = o[19:12];
		w.j_fmt.imm11 = o[11];
		w.j_fmt.imm10_1 = o[10:1];
		return w;
	endfunction

	function automatic logic [ILEN-1:0] make_jalr(logic [4:0] rd, logic [4:0] rs1);
		rv_instr_t w;
		w.i_fmt.opcode = OPC_JALR;
		w.i_fmt.rd = rd;
		w.i_fmt.rs1 = rs1;
		w.i_fmt.funct3 = 3'b000;
		w.i_fmt.imm11_0 = 12'h000;
		return w;
	endfunction

	function automatic logic [ILEN-1:0] make_branch(int off);
		rv_instr_t w;
		logic [12:0] o;
		o = 13'(off);
		w.b_fmt.opcode = OPC_BRANCH;
		w.b_fmt.funct3 = 3'b000;
		w.b_fmt.rs1 = 5'd10;
		w.b_fmt.rs2 = 5'd11;
		w.b_fmt.imm12 = o[12];
		w.b_fmt.imm11 = o[11];
		w.b_fmt.imm10_5 = o[10:5];
		w.b_fmt.imm4_1 = o[4:1];
		return w;
	endfunction

	// random word with an OP-IMM opcode so it never transfers control
	function automatic logic [ILEN-1:0] make_filler();
		logic [31:0] r;
		r = next_rand();
		return {r[31:7], 7'b0010011};
	endfunction

	function automatic logic [XLEN-1:0] word_pc(int idx);
		return RESET_PC + XLEN'(idx * 4);
	endfunction

	function automatic logic is_link(logic [4:0] r);
		return (r == REG_RA) || (r == REG_T0);
	endfunction

	// store a word together with what the model must know about it
	task automatic place_word(input int idx, input logic [ILEN-1:0] w, input logic jal,
			input logic jalr, input logic br, input logic [4:0] rd, input logic [4:0] rs1,
			input int off);
		prog[idx] = w;
		prog_jal[idx] = jal;
		prog_jalr[idx] = jalr;
		prog_br[idx] = br;
		prog_call[idx] = (jal || jalr) && is_link(rd);
		prog_ret[idx] = jalr && is_link(rs1) && (rs1 != rd);
		prog_off[idx] = off;
	endtask

	// loop 2..6 holds a call and return and exits by misprediction
	task automatic build_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			place_word(i, make_filler(), 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 0);
		end
		place_word(2, make_branch(12), 1'b0, 1'b0, 1'b1, 5'd0, 5'd10, 12);
		place_word(4, make_jal(REG_RA, 16), 1'b1, 1'b0, 1'b0, REG_RA, 5'd0, 16);
		place_word(6, make_branch(-16), 1'b0, 1'b0, 1'b1, 5'd0, 5'd10, -16);
		place_word(7, make_jal(5'd0, 20), 1'b1, 1'b0, 1'b0, 5'd0, 5'd0, 20);
		place_word(9, make_jalr(5'd0, REG_RA), 1'b0, 1'b1, 1'b0, 5'd0, REG_RA, 0);
		place_word(12, make_jalr(5'd0, 5'd10), 1'b0, 1'b1, 1'b0, 5'd0, 5'd10, 0);
		place_word(14, make_jal(5'd0, -56), 1'b1, 1'b0, 1'b0, 5'd0, 5'd0, -56);
	endtask

	// reference PC model evaluated once the inputs of the cycle settle
	task automatic model_step();
		logic [XLEN:0] head;
		logic exp_mis;
		logic [XLEN-1:0] idx;
		logic in_prog;
		logic jal;
		logic jalr;
		logic br;
		logic hit;
		logic pred;
		logic exp_jalr_stall;
		logic exp_ready;
		logic exp_valid;
		logic [XLEN-1:0] target;
		head = (pred_q.size() > 0) ? pred_q[0] : '0;
		exp_mis = bru_res_valid && (bru_taken != head[XLEN]);
		idx = (exp_pc - RESET_PC) >> 2;
		in_prog = (idx < XLEN'(PROG_LEN));
		if (!in_prog) begin
			idx = '0;
		end
		jal = prog_jal[idx];
		jalr = prog_jalr[idx];
		br = prog_br[idx];
		hit = prog_ret[idx] && (stack_q.size() > 0);
		// fetch stalls on fifo_full, on a JALR without a target and on a full BHT
		exp_jalr_stall = jalr && !hit && !jalr_valid;
		exp_ready = !fifo_full && !exp_jalr_stall;
		exp_valid = exp_ready && !(br && pred_q.size() >= (1 << BHT_AW));
		assert (mispredict == exp_mis) else begin
			mismatches++;
			$display("mismatch %s mispredict expected %0b actual %0b", test_name, exp_mis,
				mispredict);
		end
		assert (instr_valid == exp_valid) else begin
			mismatches++;
			$display("mismatch %s instr_valid expected %0b actual %0b", test_name, exp_valid,
				instr_valid);
		end
		assert (bru_ready == exp_ready) else begin
			mismatches++;
			$display("mismatch %s bru_ready expected %0b actual %0b", test_name, exp_ready,
				bru_ready);
		end
		if (bru_res_valid) begin
			void'(pred_q.pop_front());
		end
		if (instr_valid) begin
			accepted++;
			assert (pc_out == exp_pc) else begin
				mismatches++;
				$display("mismatch %s pc_out expected %h actual %h", test_name, exp_pc, pc_out);
			end
			if (!in_prog) begin
				other_errors++;
				$display("expected pc %h lies outside the preloaded program", exp_pc);
			end
			assert (instr_out == prog[idx]) else begin
				mismatches++;
				$display("mismatch %s instr_out expected %h actual %h", test_name, prog[idx],
					instr_out);
			end
			if (jalr) begin
				target = hit ? stack_q[$] : jalr_pc;
			end else begin
				target = exp_pc + XLEN'(prog_off[idx]);
			end
			pred = jal || jalr || (br && prog_off[idx] < 0);
			if (br) begin
				pred_q.push_back({pred, pred ? exp_pc + XLEN'(4) : target});
			end
			if (prog_call[idx] && hit) begin
				stack_q[$] = exp_pc + XLEN'(4);
			end else if (prog_call[idx]) begin
				stack_q.push_back(exp_pc + XLEN'(4));
				if (stack_q.size() > (1 << RAS_AW)) begin
					void'(stack_q.pop_front());
				end
			end else if (hit) begin
				void'(stack_q.pop_back());
			end
			if (exp_mis) begin
				test_name = "mispredict";
				exp_pc = head[XLEN-1:0];
			end else if (pred) begin
				test_name = jal ? "jal" : (jalr ? (hit ? "return" : "jalr") : "branch");
				exp_pc = target;
			end else begin
				test_name = br ? "branch" : "sequential";
				exp_pc = exp_pc + XLEN'(4);
			end
		end
	endtask

	initial begin
		logic [31:0] r;
		int targets [4];
		seed = 32'h1855;
		targets = '{0, 3, 8, 13};
		rst_n = 1'b0;
		jalr_valid = 1'b0;
		jalr_pc = '0;
		bru_res_valid = 1'b0;
		bru_taken = 1'b0;
		fifo_full = 1'b0;
		imem_we = 1'b0;
		imem_waddr = '0;
		imem_wdata = '0;
		mismatches = 0;
		other_errors = 0;
		assert_fails = 0;
		accepted = 0;
		jalr_wait = 0;
		res_delay = 0;
		exp_pc = RESET_PC;
		test_name = "sequential";
		build_program();
		// preload while reset is held
		for (int i = 0; i < PROG_LEN; i++) begin
			@(posedge CLK);
			#2;
			imem_we = 1'b1;
			imem_waddr = ITCM_AW'(i);
			imem_wdata = prog[i];
		end
		@(posedge CLK);
		#2;
		imem_we = 1'b0;
		rst_n = 1'b1;
		while (accepted < N_INSTR) begin
			@(posedge CLK);
			#2;
			r = next_rand();
			jalr_valid = 1'b0;
			bru_res_valid = 1'b0;
			bru_taken = 1'b0;
			fifo_full = (r[1:0] == 2'b00);
			#1;
			// JALR waiting for execute
			if (!fifo_full && !bru_ready) begin
				assert (!instr_valid) else begin
					other_errors++;
					$display("instruction accepted while JALR stalled");
				end
				if (jalr_wait == 0) begin
					jalr_wait = 1 + int'(r[5:4]);
				end
				jalr_wait--;
				if (jalr_wait == 0) begin
					jalr_valid = 1'b1;
					jalr_pc = word_pc(targets[r[9:8]]);
				end
			end
			#1;
			// in order resolution where a stalled cycle only gets correct outcomes
			if (pred_q.size() > 0 && !fifo_full && bru_ready) begin
				if (res_delay > 0) begin
					res_delay--;
				end else begin
					bru_res_valid = 1'b1;
					bru_taken = instr_valid ? r[12] : pred_q[0][XLEN];
					res_delay = int'(r[18:16]) % 6;
				end
			end
			#1;
			model_step();
		end
		assert_fails = u_fetch_top.u_fetch_asserts.fail_count;
		$display("errors: mismatches %0d, other %0d, assertions %0d", mismatches, other_errors,
			assert_fails);
		if (mismatches == 0 && other_errors == 0 && assert_fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: fetch.f
src/fetch_pkg.sv
src/itcm.sv
src/branch_fifo.sv
src/return_stack.sv
src/instr_predecode.sv
src/pc_generate.sv
src/fetch_top.sv
testbench/fetch_asserts.sv
testbench/fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= fetch_tb
FILELIST ?= fetch.f

OBJ_DIR := obj_dir
BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
